// ==== source/ddr_pkg.sv ====
package ddr_pkg;

	// command opcodes on the simplified command bus
	typedef enum logic [2:0] {
		NOP = 3'd0,
		ACT = 3'd1,
		RD  = 3'd2,
		WR  = 3'd3,
		PRE = 3'd4,
		REF = 3'd5
	} ddr_op_e;

	// device geometry
	localparam int BANK_W    = 3;
	localparam int ROW_W     = 17;
	localparam int COL_W     = 10;
	localparam int NUM_BANKS = 8;

	// timing, all in controller clock cycles
	localparam int T_RCD    = 4;   // ACT to RD/WR, same bank
	localparam int T_RP     = 3;   // PRE to ACT, same bank
	localparam int T_RFC    = 10;  // REF to next command
	localparam int T_REFI   = 200; // refresh interval
	localparam int READ_LAT = 5;   // RD to data on dq_in

	// counter widths for the sequencer
	localparam int WAIT_W = 4;                // must hold the largest of T_RCD, T_RP, T_RFC
	localparam int REFI_W = $clog2(T_REFI);

	// one command per cycle
	// row only meaningful for ACT, col only for RD/WR
	typedef struct packed {
		ddr_op_e           op;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  col;
	} ddr_cmd_t;

endpackage

// ==== source/txn_pkg.sv ====
package txn_pkg;
	import ddr_pkg::*;

	localparam int DATA_W = 16;
	localparam int ADDR_W = 30; // col + bank + row, low to high

	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

	// what the request needs at its bank
	typedef enum logic [1:0] {
		HIT      = 2'd0, // row already open
		MISS     = 2'd1, // bank closed, activate first
		CONFLICT = 2'd2  // other row open, precharge then activate
	} need_e;

	// request as accepted from the host side
	typedef struct packed {
		logic              is_write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} req_t;

	// request after address split and bank lookup
	typedef struct packed {
		logic              is_write;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  col;
		logic [DATA_W-1:0] data;
		need_e             need;
	} dec_req_t;

endpackage

// ==== source/req_queue.sv ====
`timescale 1ns/1ps

module req_queue import txn_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic              in_request_type,
	input  logic [ADDR_W-1:0] in_request_address,
	input  logic [DATA_W-1:0] in_request_data,
	output logic              out_busy,
	output req_t              q_req,
	output logic              q_valid,
	input  logic              q_pop
);

	req_t              mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr, rd_ptr;
	logic [QPTR_W:0]   count, count_nxt;
	logic              push;

	assign push    = in_valid && !out_busy; // busy is exactly the full flag
	assign q_valid = (count != '0);
	assign q_req   = mem[rd_ptr];

	always_comb begin
		count_nxt = count;
		if (push && !q_pop)
			count_nxt = count + 1'b1;
		else if (!push && q_pop)
			count_nxt = count - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			out_busy <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps on its own
			if (q_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count    <= count_nxt;
			out_busy <= (count_nxt == (QPTR_W+1)'(QUEUE_DEPTH));
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr].is_write <= in_request_type;
			mem[wr_ptr].addr     <= in_request_address;
			mem[wr_ptr].data     <= in_request_data;
		end
	end

endmodule

// ==== source/bank_tracker.sv ====
`timescale 1ns/1ps

module bank_tracker import ddr_pkg::*, txn_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  req_t              q_req,
	input  logic              q_valid,
	output logic              q_pop,
	output dec_req_t          d_req,
	output logic              d_valid,
	input  logic              d_ready,
	input  logic              row_open_evt,
	input  logic              row_close_evt,
	input  logic [BANK_W-1:0] evt_bank,
	input  logic [ROW_W-1:0]  evt_row
);

	logic [NUM_BANKS-1:0] row_vld;
	logic [ROW_W-1:0]     open_row [NUM_BANKS];
	dec_req_t             dec_in;

	// looks up a bank, with this cycle's events already applied
	function automatic need_e classify(input logic [BANK_W-1:0] bank,
	                                   input logic [ROW_W-1:0] row);
		logic             vld;
		logic [ROW_W-1:0] cur_row;
		vld     = row_vld[bank];
		cur_row = open_row[bank];
		if (row_open_evt && evt_bank == bank) begin
			vld     = 1'b1;
			cur_row = evt_row;
		end
		if (row_close_evt && evt_bank == bank)
			vld = 1'b0;
		if (!vld)
			return MISS;
		return (cur_row == row) ? HIT : CONFLICT;
	endfunction

	// address split: col low, then bank, then row
	always_comb begin
		dec_in.is_write = q_req.is_write;
		dec_in.col      = q_req.addr[COL_W-1:0];
		dec_in.bank     = q_req.addr[COL_W +: BANK_W];
		dec_in.row      = q_req.addr[COL_W+BANK_W +: ROW_W];
		dec_in.data     = q_req.data;
		dec_in.need     = classify(dec_in.bank, dec_in.row);
	end

	assign q_pop = q_valid && (!d_valid || d_ready); // load when empty or being taken

	// open row table, follows the commands the sequencer issues
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			row_vld <= '0;
		else if (row_close_evt)
			row_vld[evt_bank] <= 1'b0;
		else if (row_open_evt)
			row_vld[evt_bank] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (row_open_evt)
			open_row[evt_bank] <= evt_row;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			d_valid <= 1'b0;
		else if (q_pop)
			d_valid <= 1'b1;
		else if (d_ready)
			d_valid <= 1'b0;
	end

	// a held entry is reclassified every cycle, so need is current when taken
	always_ff @(posedge clk) begin
		if (q_pop)
			d_req <= dec_in;
		else if (d_valid)
			d_req.need <= classify(d_req.bank, d_req.row);
	end

endmodule

// ==== source/cmd_sequencer.sv ====
`timescale 1ns/1ps

module cmd_sequencer import ddr_pkg::*, txn_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  dec_req_t          d_req,
	input  logic              d_valid,
	output logic              d_ready,
	output logic              row_open_evt,
	output logic              row_close_evt,
	output logic [BANK_W-1:0] evt_bank,
	output logic [ROW_W-1:0]  evt_row,
	output ddr_cmd_t          cmd,
	output logic              cs_n,
	output logic [DATA_W-1:0] dq_out,
	output logic              dq_oe,
	output logic              write_done,
	output logic              rd_issue
);

	typedef enum logic [2:0] {
		IDLE, PRECHARGE, ACTIVATE, ACCESS, REFRESH_PRE, REFRESH, REFRESH_WAIT
	} seq_state_e;

	seq_state_e           state;
	dec_req_t             cur;       // request being served
	logic [WAIT_W-1:0]    wait_cnt;  // each state issues its command when this reaches zero
	logic [REFI_W-1:0]    ref_cnt;
	logic                 ref_pending;
	logic [NUM_BANKS-1:0] open_mask;
	logic [BANK_W-1:0]    pre_bank;  // lowest open bank, for refresh precharge

	assign d_ready = (state == IDLE) && !ref_pending; // refresh wins over a new request

	always_comb begin
		pre_bank = '0;
		for (int b = NUM_BANKS-1; b >= 0; b--) begin
			if (open_mask[b])
				pre_bank = BANK_W'(b);
		end
	end

	// command decode from state, at most one per cycle
	always_comb begin
		cmd.op   = NOP;
		cmd.bank = cur.bank;
		cmd.row  = cur.row;
		cmd.col  = cur.col;
		case (state)
			PRECHARGE:   if (wait_cnt == '0) cmd.op = PRE;
			ACTIVATE:    if (wait_cnt == '0) cmd.op = ACT;
			ACCESS:      if (wait_cnt == '0) cmd.op = cur.is_write ? WR : RD;
			REFRESH_PRE: begin
				if (open_mask != '0) begin
					cmd.op   = PRE;
					cmd.bank = pre_bank;
				end
			end
			REFRESH:     cmd.op = REF;
			default:     ;
		endcase
	end

	assign cs_n          = (cmd.op == NOP);
	assign dq_oe         = (cmd.op == WR);
	assign write_done    = dq_oe;            // write completes with its WR
	assign dq_out        = cur.data;
	assign rd_issue      = (cmd.op == RD);
	assign row_open_evt  = (cmd.op == ACT);
	assign row_close_evt = (cmd.op == PRE);
	assign evt_bank      = cmd.bank;
	assign evt_row       = cmd.row;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					wait_cnt <= '0;
					if (ref_pending)
						state <= REFRESH_PRE;
					else if (d_valid) begin
						case (d_req.need)
							HIT:      state <= ACCESS;
							MISS:     state <= ACTIVATE;
							default:  state <= PRECHARGE;
						endcase
					end
				end
				PRECHARGE: begin
					if (wait_cnt == '0) begin
						state    <= ACTIVATE;
						wait_cnt <= WAIT_W'(T_RP - 1);
					end else
						wait_cnt <= wait_cnt - 1'b1;
				end
				ACTIVATE: begin
					if (wait_cnt == '0) begin
						state    <= ACCESS;
						wait_cnt <= WAIT_W'(T_RCD - 1);
					end else
						wait_cnt <= wait_cnt - 1'b1;
				end
				ACCESS: begin
					if (wait_cnt == '0)
						state <= IDLE;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				REFRESH_PRE: begin
					if (open_mask != '0)
						wait_cnt <= WAIT_W'(T_RP - 1); // tRP counts from the last PRE
					else if (wait_cnt == '0)
						state <= REFRESH;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				REFRESH: begin
					state    <= REFRESH_WAIT;
					wait_cnt <= WAIT_W'(T_RFC - 1);
				end
				default: begin // REFRESH_WAIT
					if (wait_cnt == '0)
						state <= IDLE;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (d_valid && d_ready)
			cur <= d_req;
	end

	// open banks as seen by the sequencer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			open_mask <= '0;
		else if (cmd.op == ACT)
			open_mask[cmd.bank] <= 1'b1;
		else if (cmd.op == PRE)
			open_mask[cmd.bank] <= 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_cnt     <= '0;
			ref_pending <= 1'b0;
		end else begin
			if (ref_cnt == REFI_W'(T_REFI - 1)) begin
				ref_cnt     <= '0;
				ref_pending <= 1'b1;
			end else
				ref_cnt <= ref_cnt + 1'b1;
			if (state == REFRESH)
				ref_pending <= 1'b0;
		end
	end

endmodule

// ==== source/read_return.sv ====
`timescale 1ns/1ps

module read_return import ddr_pkg::*, txn_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rd_issue,
	input  logic [DATA_W-1:0] dq_in,
	output logic              read_done,
	output logic [DATA_W-1:0] data_out
);

	// bit k set means a read issued k+1 cycles ago
	logic [READ_LAT-1:0] rd_line;
	logic                data_here;

	assign data_here = rd_line[READ_LAT-1]; // dq_in carries read data this cycle

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_line   <= '0;
			read_done <= 1'b0;
		end else begin
			rd_line   <= {rd_line[READ_LAT-2:0], rd_issue};
			read_done <= data_here; // one-cycle pulse per read
		end
	end

	// capture register, holds the last read value between pulses
	always_ff @(posedge clk) begin
		if (data_here)
			data_out <= dq_in;
	end

endmodule

// ==== source/memory_controller.sv ====
`timescale 1ns/1ps

module memory_controller import ddr_pkg::*, txn_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic              in_request_type,
	input  logic [ADDR_W-1:0] in_request_address,
	input  logic [DATA_W-1:0] in_request_data,
	output logic              out_busy,
	output logic              write_done,
	output logic              read_done,
	output logic [DATA_W-1:0] data_out,
	output ddr_cmd_t          cmd,
	output logic              cs_n,
	output logic [DATA_W-1:0] dq_out,
	output logic              dq_oe,
	input  logic [DATA_W-1:0] dq_in
);

	req_t              q_req;
	logic              q_valid, q_pop;
	dec_req_t          d_req;
	logic              d_valid, d_ready;
	logic              row_open_evt, row_close_evt;
	logic [BANK_W-1:0] evt_bank;
	logic [ROW_W-1:0]  evt_row;
	logic              rd_issue;

	req_queue u_req_queue (
		.clk, .rst_n, .in_valid, .in_request_type, .in_request_address,
		.in_request_data, .out_busy, .q_req, .q_valid, .q_pop
	);

	bank_tracker u_bank_tracker (
		.clk, .rst_n, .q_req, .q_valid, .q_pop, .d_req, .d_valid, .d_ready,
		.row_open_evt, .row_close_evt, .evt_bank, .evt_row
	);

	cmd_sequencer u_cmd_sequencer (
		.clk, .rst_n, .d_req, .d_valid, .d_ready, .row_open_evt, .row_close_evt,
		.evt_bank, .evt_row, .cmd, .cs_n, .dq_out, .dq_oe, .write_done, .rd_issue
	);

	read_return u_read_return (
		.clk, .rst_n, .rd_issue, .dq_in, .read_done, .data_out
	);

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam time HALF_PERIOD = 20ns; // 40 ns period

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset held for three rising edges, released just after the third
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== verif/ddr_mem_model.sv ====
`timescale 1ns/1ps

module ddr_mem_model import ddr_pkg::*, txn_pkg::*; (
	input  logic              clk,
	input  ddr_cmd_t          cmd,
	input  logic              cs_n,
	input  logic [DATA_W-1:0] dq_out,
	input  logic              dq_oe,
	output logic [DATA_W-1:0] dq_in
);

	logic [DATA_W-1:0] store [logic [ADDR_W-1:0]]; // sparse, only written words
	logic [ROW_W-1:0]  open_row [NUM_BANKS];
	logic [DATA_W-1:0] rd_pipe [READ_LAT];       // read data on its way to dq_in

	// rebuilds the host address from the open row of the bank
	function automatic logic [ADDR_W-1:0] word_addr(input logic [BANK_W-1:0] bank,
	                                                input logic [COL_W-1:0] col);
		return {open_row[bank], bank, col};
	endfunction

	assign dq_in = rd_pipe[READ_LAT-1];

	initial begin
		foreach (rd_pipe[k])
			rd_pipe[k] = '0;
	end

	always @(posedge clk) begin
		for (int k = READ_LAT-1; k > 0; k--)
			rd_pipe[k] <= rd_pipe[k-1];
		rd_pipe[0] <= '0; // bus idles at zero
		if (!cs_n) begin
			case (cmd.op)
				ACT: open_row[cmd.bank] <= cmd.row;
				WR: begin
					if (dq_oe)
						store[word_addr(cmd.bank, cmd.col)] = dq_out;
				end
				RD: begin
					if (store.exists(word_addr(cmd.bank, cmd.col)))
						rd_pipe[0] <= store[word_addr(cmd.bank, cmd.col)];
				end
				default: ; // PRE and REF only change state the model ignores
			endcase
		end
	end

endmodule

// ==== verif/mc_chk.sv ====
`timescale 1ns/1ps

module mc_chk import ddr_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input ddr_cmd_t cmd,
	input logic     cs_n,
	input logic     dq_oe
);

	logic [NUM_BANKS-1:0] bank_open;
	logic [3:0]           act_age [NUM_BANKS]; // cycles since the bank's ACT, saturating
	int                   fail_cnt = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_open <= '0;
			for (int b = 0; b < NUM_BANKS; b++)
				act_age[b] <= '1;
		end else begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (act_age[b] != '1)
					act_age[b] <= act_age[b] + 1'b1;
			end
			if (!cs_n && cmd.op == ACT) begin
				bank_open[cmd.bank] <= 1'b1;
				act_age[cmd.bank]   <= 4'd1;
			end else if (!cs_n && cmd.op == PRE)
				bank_open[cmd.bank] <= 1'b0;
		end
	end

	access_open_bank: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd.op inside {RD, WR}) |-> (bank_open[cmd.bank] && act_age[cmd.bank] >= T_RCD))
		else begin
			$error("RD or WR to a closed bank or before tRCD, bank %0d", cmd.bank);
			fail_cnt++;
		end

	act_closed_bank: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd.op == ACT) |-> !bank_open[cmd.bank])
		else begin
			$error("ACT to bank %0d which is already open", cmd.bank);
			fail_cnt++;
		end

	oe_with_write: assert property (@(posedge clk) disable iff (!rst_n)
		dq_oe |-> (cmd.op == WR))
		else begin
			$error("dq_oe high without a WR command");
			fail_cnt++;
		end

	nop_when_deselected: assert property (@(posedge clk) disable iff (!rst_n)
		cs_n |-> (cmd.op == NOP))
		else begin
			$error("command other than NOP while cs_n is high");
			fail_cnt++;
		end

endmodule

// ==== verif/mc_tb.sv ====
`timescale 1ns/1ps

module mc_tb import ddr_pkg::*, txn_pkg::*; ();

	localparam int N_REF_WORDS  = 1023;
	localparam int N_RANDOM     = 400;
	localparam int WAIT_LIMIT   = 2000; // cycles, for any single wait
	localparam int DRAIN_CYCLES = 100;
	localparam int MIN_REFRESH  = 3;

	logic              clk, rst_n;
	logic              in_valid, in_request_type;
	logic [ADDR_W-1:0] in_request_address;
	logic [DATA_W-1:0] in_request_data;
	logic              out_busy, write_done, read_done;
	logic [DATA_W-1:0] data_out, dq_out, dq_in;
	ddr_cmd_t          cmd;
	logic              cs_n, dq_oe;

	logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
	logic [DATA_W-1:0] exp_data [$];  // expected reads, submit order
	logic [ADDR_W-1:0] exp_addr [$];
	logic [31:0]       lfsr;
	int                n_writes = 0;
	int                wr_done_cnt = 0;
	int                ref_seen = 0;

	clk_gen u_clk_gen (.clk, .rst_n);

	memory_controller uut (
		.clk, .rst_n, .in_valid, .in_request_type, .in_request_address, .in_request_data,
		.out_busy, .write_done, .read_done, .data_out, .cmd, .cs_n, .dq_out, .dq_oe, .dq_in
	);

	ddr_mem_model u_mem (.clk, .cmd, .cs_n, .dq_out, .dq_oe, .dq_in);

	bind memory_controller mc_chk u_mc_chk (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .cs_n(cs_n), .dq_oe(dq_oe)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// last written value of an address, zero if never written
	function automatic logic [DATA_W-1:0] shadow_access(input logic is_write,
	                                                    input logic [ADDR_W-1:0] addr,
	                                                    input logic [DATA_W-1:0] data);
		if (is_write)
			shadow[addr] = data;
		return shadow.exists(addr) ? shadow[addr] : '0;
	endfunction

	// called 1 ns after a rising edge, returns 1 ns after the accepting edge
	task automatic submit(input logic is_write, input logic [ADDR_W-1:0] addr,
	                      input logic [DATA_W-1:0] data);
		int cycles;
		cycles = 0;
		while (out_busy) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_run("timeout waiting for out_busy to drop");
		end
		in_valid           = 1'b1;
		in_request_type    = is_write;
		in_request_address = addr;
		in_request_data    = data;
		if (is_write)
			n_writes++;
		else begin
			exp_data.push_back(shadow_access(1'b0, addr, data));
			exp_addr.push_back(addr);
		end
		if (is_write)
			void'(shadow_access(1'b1, addr, data));
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0 || wr_done_cnt < n_writes) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_run("timeout waiting for outstanding requests to complete");
		end
	endtask

	// compare process, outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && read_done) begin
			assert (exp_data.size() != 0) begin
				assert (data_out == exp_data[0]) begin
					void'(exp_data.pop_front());
					void'(exp_addr.pop_front());
				end else
					stop_run($sformatf("FAIL data_out=%h expected=%h addr=%h",
					                   data_out, exp_data[0], exp_addr[0]));
			end else
				stop_run("read_done arrived with no read outstanding");
		end
	end

	always @(negedge clk) begin
		if (rst_n && write_done)
			wr_done_cnt++;
		if (rst_n && !cs_n && cmd.op == REF)
			ref_seen++;
	end

	initial begin
		int cycles;
		logic [ROW_W-1:0]  row;
		logic [BANK_W-1:0] bank;
		logic [COL_W-1:0]  col;
		in_valid           = 1'b0;
		in_request_type    = 1'b0;
		in_request_address = '0;
		in_request_data    = '0;
		lfsr               = 32'h24b524a3;

		cycles = 0;
		while (!rst_n) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 10)
				stop_run("reset was never released");
		end

		// idle outputs before the first request
		repeat (3) begin
			assert (!out_busy && !write_done && !read_done && !dq_oe && cs_n)
				else stop_run("controller outputs not idle after reset");
			@(posedge clk);
			#1;
		end

		// reference pattern, data equals address
		for (int a = 0; a < N_REF_WORDS; a++)
			submit(1'b1, ADDR_W'(a), DATA_W'(a));
		for (int a = 0; a < N_REF_WORDS; a++)
			submit(1'b0, ADDR_W'(a), '0);
		wait_idle();
		assert (wr_done_cnt == N_REF_WORDS)
			else stop_run("number of write_done pulses differs from number of writes");

		// few rows and banks, so hits, misses and conflicts all occur
		for (int i = 0; i < N_RANDOM; i++) begin
			row  = ROW_W'(rand_bits(2));
			bank = BANK_W'(rand_bits(2));
			col  = COL_W'(rand_bits(3));
			submit(1'(rand_bits(1)), {row, bank, col}, DATA_W'(rand_bits(DATA_W)));
		end
		wait_idle();

		// old data after several refreshes
		for (int a = 0; a < N_REF_WORDS; a += 31)
			submit(1'b0, ADDR_W'(a), '0);
		wait_idle();

		repeat (DRAIN_CYCLES) @(posedge clk); // any stray read_done fails in the compare process
		assert (wr_done_cnt == n_writes)
			else stop_run("write_done pulses seen without a matching write");
		assert (ref_seen >= MIN_REFRESH)
			else stop_run("too few REF commands seen on the command bus");
		assert (exp_data.size() == 0)
			else stop_run("expected-read queue not empty at the end");

		if (uut.u_mc_chk.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else
			stop_run("protocol assertions on the command bus failed");
	end

endmodule

// ==== list.f ====
source/ddr_pkg.sv
source/txn_pkg.sv
source/req_queue.sv
source/bank_tracker.sv
source/cmd_sequencer.sv
source/read_return.sv
source/memory_controller.sv
verif/clk_gen.sv
verif/ddr_mem_model.sv
verif/mc_chk.sv
verif/mc_tb.sv
